// ==== index_pkg.sv ====
// Shared widths and encodings for the index generator; all index arithmetic wraps at 16 bits
package index_pkg;

	////////////////////////////////////////////////////////////
	// Widths

	localparam int INDEX_WIDTH  = 16;	// Index, window, length, thread ID, constant
	localparam int MASK_WIDTH   = 16;	// Masked slice covers positions 0..15
	localparam int REG_NO_WIDTH = 5;

	typedef logic [INDEX_WIDTH-1:0]  index_t;
	typedef logic [REG_NO_WIDTH-1:0] reg_no_t;
	typedef logic [1:0]              sel_code_t;

	////////////////////////////////////////////////////////////
	// Operand selector codes

	// Operand a
	localparam sel_code_t IDX_SIMT  = 2'd0;	// Thread ID
	localparam sel_code_t IDX_CONST = 2'd1;	// Shared by a, b and c
	localparam sel_code_t IDX_ORIG  = 2'd2;	// Running position, shared by a, b and c
	localparam sel_code_t IDX_ZERO  = 2'd3;	// a and b only; code 3 on c is thread ID

	// Operands b and c
	localparam sel_code_t IDX_LANE  = 2'd0;

	// Selector word split into its fields, sel_a in the low bits
	typedef struct packed {
		logic      sel_s;	// Swap: c +/- m instead of m +/- c
		sel_code_t sel_c;
		sel_code_t sel_b;
		sel_code_t sel_a;
	} sel_fields_t;

	// Same 7 bits, either raw from the command or decoded by field
	typedef union packed {
		logic [6:0]  raw;
		sel_fields_t f;
	} sel_u;

	////////////////////////////////////////////////////////////
	// Request and output words

	typedef struct packed {
		logic    v;		// Index valid
		logic    slice;	// Expand as a slice
		reg_no_t no;
		sel_u    sel;
		index_t  idx;	// Base index
	} idx_req_t;

	typedef struct packed {
		logic    v;
		logic    last;	// Final element of a sequence
		reg_no_t no;
		index_t  idx;
	} idx_out_t;

endpackage

// ==== skip_ctrl.sv ====
// Mask walker for masked slices; tests one position per unstalled cycle, outputs only while active
module skip_ctrl
	import index_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  start,	// Load mask, restart at position 0
	input  logic                  stall,
	input  logic [MASK_WIDTH-1:0] mask,
	input  index_t                length,
	output logic                  hit,		// Current position has its bit set
	output index_t                offset,
	output logic                  done		// Final step of the walk
);

	localparam int POS_W = $clog2(MASK_WIDTH);

	logic                  active;
	logic [POS_W-1:0]      pos;
	logic [POS_W-1:0]      limit;
	logic [POS_W-1:0]      lim_in;
	logic [MASK_WIDTH-1:0] bits;		// Remaining set bits
	logic [MASK_WIDTH-1:0] keep;
	logic [MASK_WIDTH-1:0] pos_bit;
	logic [MASK_WIDTH-1:0] rest;

	////////////////////////////////////////////////////////////
	// Limit is min(length, MASK_WIDTH-1)

	always_comb begin
		if (length >= index_t'(MASK_WIDTH - 1)) begin
			lim_in = POS_W'(MASK_WIDTH - 1);
		end else begin
			lim_in = length[POS_W-1:0];
		end

		// Positions past the limit never count
		for (int i = 0; i < MASK_WIDTH; i++) begin
			keep[i] = (POS_W'(i) <= lim_in);
		end
	end

	////////////////////////////////////////////////////////////
	// Current step

	assign pos_bit = MASK_WIDTH'(1) << pos;
	assign rest    = bits & ~pos_bit;		// Bits below pos are already cleared

	assign hit    = active & (|(bits & pos_bit));
	assign offset = index_t'(pos);
	assign done   = active & ((rest == '0) | (pos == limit));

	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			pos    <= '0;
		end else if (start) begin
			active <= 1'b1;
			pos    <= '0;
		end else if (active & ~stall) begin
			pos <= pos + 1'b1;
			if (done) begin
				active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			bits  <= mask & keep;
			limit <= lim_in;
		end else if (active & ~stall) begin
			bits <= rest;	// Drop the bit just tested
		end
	end

endmodule

// ==== index_unit.sv ====
// One lane; first element one cycle after accept, requests ignored while stalled or busy
module index_unit
	import index_pkg::*;
#(
	parameter int LANE_ID = 0
)(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  stall,
	input  logic                  req,			// One-cycle request pulse
	input  logic                  masked_read,
	input  idx_req_t              cfg,
	input  index_t                window,
	input  index_t                length,
	input  index_t                thread_id,
	input  index_t                constant,
	input  logic                  sign,			// 1 subtracts
	input  logic [MASK_WIDTH-1:0] mask,
	output idx_out_t              out,
	output logic                  busy
);

	// Everything captured on acceptance
	typedef struct packed {
		idx_req_t cfg;
		index_t   window;
		index_t   length;
		index_t   thread_id;
		index_t   constant;
		logic     sign;
		logic     masked;
	} ctx_t;

	ctx_t   ctx_in;
	ctx_t   r_ctx;
	ctx_t   ctx;			// Live inputs in the accept cycle, captured copy after

	logic   accept;
	logic   accept_slice;
	logic   step;
	logic   plain_go;
	logic   mask_go;
	logic   at_end;

	logic   busy_r;
	logic   gen;			// Elements still to compute
	logic   r_v;
	logic   r_last;
	index_t r_idx;
	index_t count;			// Number of the next element
	index_t win_off;		// Window offset of the next element

	index_t eff_cnt;
	index_t eff_off;
	index_t off_next;
	index_t pos;
	index_t lane_val;
	index_t opa;
	index_t opb;
	index_t opc;
	index_t prod;
	index_t s1;
	index_t s2;
	index_t result;

	logic   skip_hit;
	logic   skip_done;
	index_t skip_offset;

	assign ctx_in = '{cfg: cfg, window: window, length: length, thread_id: thread_id,
	                  constant: constant, sign: sign, masked: masked_read};

	assign accept       = req & ~stall & ~busy_r;
	assign accept_slice = accept & cfg.slice;
	assign step         = gen & ~stall;
	assign ctx          = accept ? ctx_in : r_ctx;
	assign plain_go     = (accept_slice | step) & ~ctx.masked;
	assign mask_go      = step & ctx.masked;

	////////////////////////////////////////////////////////////
	// Position tracking

	assign eff_cnt  = accept ? '0 : count;
	assign eff_off  = accept ? '0 : win_off;
	assign at_end   = (eff_cnt == ctx.length);
	assign off_next = (eff_off == ctx.window) ? '0 : eff_off + 1'b1;	// Wrap at window
	assign pos      = ctx.cfg.idx + (ctx.masked ? skip_offset : eff_off);

	////////////////////////////////////////////////////////////
	// Operand select and index arithmetic

	assign lane_val = index_t'(LANE_ID);

	always_comb begin
		case (ctx.cfg.sel.f.sel_a)
			IDX_SIMT:  opa = ctx.thread_id;
			IDX_CONST: opa = ctx.constant;
			IDX_ORIG:  opa = pos;
			default:   opa = '0;
		endcase

		case (ctx.cfg.sel.f.sel_b)
			IDX_LANE:  opb = lane_val;
			IDX_CONST: opb = ctx.constant;
			IDX_ORIG:  opb = pos;
			default:   opb = '0;
		endcase

		case (ctx.cfg.sel.f.sel_c)
			IDX_LANE:  opc = lane_val;
			IDX_CONST: opc = ctx.constant;
			IDX_ORIG:  opc = pos;
			default:   opc = ctx.thread_id;	// Code 3 on c
		endcase
	end

	assign prod   = opa * opb;
	assign s1     = ctx.cfg.sel.f.sel_s ? opc : prod;
	assign s2     = ctx.cfg.sel.f.sel_s ? prod : opc;
	assign result = ctx.sign ? s1 - s2 : s1 + s2;

	////////////////////////////////////////////////////////////
	// Sequencing

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_r  <= 1'b0;
			gen     <= 1'b0;
			r_v     <= 1'b0;
			r_last  <= 1'b0;
			count   <= '0;
			win_off <= '0;
		end else if (accept & ~cfg.slice) begin		// Pass-through
			r_v    <= cfg.v;
			r_last <= 1'b1;
		end else if (accept_slice & masked_read) begin	// Skip walker starts next cycle
			r_v    <= 1'b0;
			r_last <= 1'b0;
			gen    <= 1'b1;
			busy_r <= 1'b1;
		end else if (plain_go) begin
			r_v     <= 1'b1;
			r_last  <= at_end;
			gen     <= ~at_end;
			count   <= eff_cnt + 1'b1;
			win_off <= off_next;
			if (accept) begin
				busy_r <= 1'b1;
			end
		end else if (mask_go) begin
			r_v    <= skip_hit;
			r_last <= skip_done;	// No set bit at all gives v=0, last=1
			gen    <= ~skip_done;
		end else if (~stall) begin
			r_v    <= 1'b0;
			r_last <= 1'b0;
			if (r_last) begin
				busy_r <= 1'b0;	// Last element went out this cycle
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			r_ctx <= ctx_in;
		end

		if (accept & ~cfg.slice) begin
			r_idx <= cfg.idx;
		end else if (plain_go | (mask_go & skip_hit)) begin
			r_idx <= result;
		end
	end

	skip_ctrl u_skip (
		.clock  (clock),
		.reset  (reset),
		.start  (accept_slice & masked_read),
		.stall  (stall),
		.mask   (mask),
		.length (length),
		.hit    (skip_hit),
		.offset (skip_offset),
		.done   (skip_done)
	);

	// Stall hides the held element until it can be taken
	always_comb begin
		out.v    = r_v & ~stall;
		out.last = r_last & ~stall;
		out.no   = r_ctx.cfg.no;
		out.idx  = r_idx;
	end

	assign busy = busy_r;

endmodule

// ==== index_top.sv ====
// Lane array; all lanes share one request and run in lockstep, busy is the OR over lanes
module index_top
	import index_pkg::*;
#(
	parameter int NUM_LANES = 4
)(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  stall,
	input  logic                  req,
	input  logic                  masked_read,
	input  idx_req_t              cfg,
	input  index_t                window,
	input  index_t                length,
	input  index_t                thread_id,
	input  index_t                constant,
	input  logic                  sign,
	input  logic [MASK_WIDTH-1:0] mask,
	output idx_out_t              out [NUM_LANES],
	output logic                  busy
);

	logic [NUM_LANES-1:0] lane_busy;

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		index_unit #(
			.LANE_ID (g)		// Lane number feeds the b and c operands
		) u_lane (
			.clock       (clock),
			.reset       (reset),
			.stall       (stall),
			.req         (req),
			.masked_read (masked_read),
			.cfg         (cfg),
			.window      (window),
			.length      (length),
			.thread_id   (thread_id),
			.constant    (constant),
			.sign        (sign),
			.mask        (mask),
			.out         (out[g]),
			.busy        (lane_busy[g])
		);
	end

	assign busy = |lane_busy;

endmodule

// ==== tb_index_model.svh ====
// Expected outputs of one lane; include inside the testbench module after stim_t, expect_t, exp_q
`ifndef TB_INDEX_MODEL_SVH
`define TB_INDEX_MODEL_SVH

// Affine expression for one element at running position orig
function automatic index_t expr_value(input stim_t s, input int lane, input index_t orig);
	index_t a;
	index_t b;
	index_t c;
	index_t m;

	if (s.cfg.sel.f.sel_a == IDX_SIMT)       a = s.thread_id;
	else if (s.cfg.sel.f.sel_a == IDX_CONST) a = s.constant;
	else if (s.cfg.sel.f.sel_a == IDX_ORIG)  a = orig;
	else                                     a = '0;

	if (s.cfg.sel.f.sel_b == IDX_LANE)       b = index_t'(lane);
	else if (s.cfg.sel.f.sel_b == IDX_CONST) b = s.constant;
	else if (s.cfg.sel.f.sel_b == IDX_ORIG)  b = orig;
	else                                     b = '0;

	if (s.cfg.sel.f.sel_c == IDX_LANE)       c = index_t'(lane);
	else if (s.cfg.sel.f.sel_c == IDX_CONST) c = s.constant;
	else if (s.cfg.sel.f.sel_c == IDX_ORIG)  c = orig;
	else                                     c = s.thread_id;	// Code 3 on c

	m = a * b;	// Wraps at 16 bits
	if (s.cfg.sel.f.sel_s) begin
		return s.sign ? c - m : c + m;
	end
	return s.sign ? m - c : m + c;
endfunction

// Fills the expected queue of one lane for one accepted request
task automatic expect_lane(input int lane, input stim_t s);
	expect_t e;
	int      lim;
	int      last_k;

	e.o.no      = s.cfg.no;
	e.idx_known = 1'b1;
	if (!s.cfg.slice) begin
		e.o.v    = s.cfg.v;
		e.o.last = 1'b1;
		e.o.idx  = s.cfg.idx;
		exp_q[lane].push_back(e);
	end else if (!s.masked) begin
		for (int k = 0; k <= int'(s.length); k++) begin
			e.o.v    = 1'b1;
			e.o.last = (k == int'(s.length));
			e.o.idx  = expr_value(s, lane, s.cfg.idx + index_t'(k % (int'(s.window) + 1)));
			exp_q[lane].push_back(e);
		end
	end else begin
		lim    = (s.length > index_t'(MASK_WIDTH - 1)) ? MASK_WIDTH - 1 : int'(s.length);
		last_k = -1;
		for (int k = 0; k <= lim; k++) begin
			if (s.mask[k]) last_k = k;
		end
		if (last_k < 0) begin	// Empty mask gives one invalid last
			e.o.v       = 1'b0;
			e.o.last    = 1'b1;
			e.o.idx     = '0;
			e.idx_known = 1'b0;
			exp_q[lane].push_back(e);
		end else begin
			for (int k = 0; k <= last_k; k++) begin
				if (s.mask[k]) begin
					e.o.v    = 1'b1;
					e.o.last = (k == last_k);
					e.o.idx  = expr_value(s, lane, s.cfg.idx + index_t'(k));
					exp_q[lane].push_back(e);
				end
			end
		end
	end
endtask

`endif

// ==== tb_index_top.sv ====
// Testbench for index_top with 4 lanes; random stimulus from a fixed xorshift seed, stall rate 1/4
module tb_index_top
	import index_pkg::*;
();

	localparam int N_LANES    = 4;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYC  = 8;
	localparam int MAX_LEN    = 20;
	localparam int N_PASS     = 4;
	localparam int N_PLAIN    = 8;
	localparam int N_SIGN     = 8;
	localparam int N_MASK     = 9;	// Last one has an empty mask
	localparam int N_STALL    = 6;
	localparam int SEQ_CYC    = MAX_LEN + 24;	// Longest sequence plus issue and drain
	localparam int WATCHDOG_CYC = RESET_CYC + 20
		+ (N_PASS + N_PLAIN + N_SIGN + N_MASK + 4 * N_STALL) * SEQ_CYC;

	typedef struct packed {
		idx_req_t              cfg;
		index_t                window;
		index_t                length;
		index_t                thread_id;
		index_t                constant;
		logic                  sign;
		logic                  masked;
		logic [MASK_WIDTH-1:0] mask;
	} stim_t;

	typedef struct packed {
		idx_out_t o;
		logic     idx_known;	// Index is don't care on an empty masked slice
	} expect_t;

	logic                  clock;
	logic                  reset;
	logic                  stall;
	logic                  req;
	logic                  masked_read;
	idx_req_t              cfg;
	index_t                window;
	index_t                length;
	index_t                thread_id;
	index_t                constant;
	logic                  sign;
	logic [MASK_WIDTH-1:0] mask;
	idx_out_t              lane_out [N_LANES];
	logic                  busy;

	expect_t     exp_q [N_LANES][$];
	int unsigned rng_state = 92;
	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          errors_at_start;
	string       test_name;

	`include "tb_index_model.svh"

	index_top #(
		.NUM_LANES (N_LANES)
	) UUT (
		.clock       (clock),
		.reset       (reset),
		.stall       (stall),
		.req         (req),
		.masked_read (masked_read),
		.cfg         (cfg),
		.window      (window),
		.length      (length),
		.thread_id   (thread_id),
		.constant    (constant),
		.sign        (sign),
		.mask        (mask),
		.out         (lane_out),
		.busy        (busy)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	////////////////////////////////////////////////////////////
	// Stimulus helpers

	function automatic int unsigned rand_next();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic stim_t random_stim();
		stim_t s;
		s.cfg.v       = 1'b1;
		s.cfg.slice   = 1'b1;
		s.cfg.no      = reg_no_t'(rand_next());
		s.cfg.sel.raw = 7'(rand_next());
		s.cfg.idx     = index_t'(rand_next());
		s.window      = index_t'(rand_next() % 6);
		s.length      = index_t'(rand_next() % (MAX_LEN + 1));
		s.thread_id   = index_t'(rand_next());
		s.constant    = index_t'(rand_next());
		s.sign        = 1'b0;
		s.masked      = 1'b0;
		s.mask        = MASK_WIDTH'(rand_next());
		return s;
	endfunction

	task automatic drive_inputs(input stim_t s);
		cfg         <= s.cfg;
		window      <= s.window;
		length      <= s.length;
		thread_id   <= s.thread_id;
		constant    <= s.constant;
		sign        <= s.sign;
		masked_read <= s.masked;
		mask        <= s.mask;
	endtask

	// Request pulse with stall low; expected queues filled at the same time
	task automatic issue_request(input stim_t s);
		@(posedge clock);
		drive_inputs(s);
		req   <= 1'b1;
		stall <= 1'b0;
		for (int l = 0; l < N_LANES; l++) begin
			expect_lane(l, s);
		end
		@(posedge clock);
		req <= 1'b0;
	endtask

	function automatic bit lanes_empty();
		for (int l = 0; l < N_LANES; l++) begin
			if (exp_q[l].size() != 0) return 1'b0;
		end
		return 1'b1;
	endfunction

	// Runs until every expected output was seen and busy fell; poke sends one request while busy
	task automatic run_until_idle(input bit with_stall, input bit poke, input bit slice);
		bit    idle;
		bit    empty;
		bit    poke_now;
		bit    poked;
		stim_t g;
		idle     = 1'b0;
		poke_now = 1'b0;
		poked    = 1'b0;
		while (!idle) begin
			@(posedge clock);
			if (poke_now) begin
				g           = random_stim();
				g.cfg.slice = 1'b0;	// Would show up as a stray output if taken
				cfg   <= g.cfg;
				req   <= 1'b1;
				stall <= 1'b0;
				poked = 1'b1;
			end else begin
				req   <= 1'b0;
				stall <= with_stall ? (rand_next() % 4 == 0) : 1'b0;
			end
			@(negedge clock);
			empty = lanes_empty();
			// Busy from the cycle after a slice is taken until its last element is out
			assert (busy == (slice && !empty)) else begin
				$display("CHECK FAILED at time %0t: busy=%0b, expected %0b",
				         $time, busy, slice && !empty);
				errors++;
			end
			poke_now = poke && !poked && exp_q[0].size() >= 2;
			idle     = empty && !busy;
		end
		@(posedge clock);
		stall <= 1'b0;
	endtask

	task automatic run_case(input stim_t s, input bit with_stall, input bit poke);
		issue_request(s);
		run_until_idle(with_stall, poke, s.cfg.slice);
	endtask

	task automatic begin_test(input string name);
		test_name       = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		for (int l = 0; l < N_LANES; l++) begin
			assert (exp_q[l].size() == 0) else begin
				$display("Lane %0d still waits for %0d outputs at the end of %s",
				         l, exp_q[l].size(), test_name);
				errors++;
			end
			exp_q[l].delete();
		end
		tests_run++;
		if (errors != errors_at_start) tests_failed++;
		$display("%s: %s", test_name, (errors == errors_at_start) ? "ok" : "FAILED");
	endtask

	////////////////////////////////////////////////////////////
	// Output monitor

	always @(posedge clock) begin : monitor
		expect_t e;
		bit      ok;
		if (!reset) begin
			for (int l = 0; l < N_LANES; l++) begin
				assert (!(stall && (lane_out[l].v || lane_out[l].last))) else begin
					$display("CHECK FAILED at time %0t: lane %0d output while stalled", $time, l);
					errors++;
				end
				if (lane_out[l].v || lane_out[l].last) begin
					assert (exp_q[l].size() != 0) else begin
						$display("CHECK FAILED at time %0t: lane %0d unexpected output idx=%h",
						         $time, l, lane_out[l].idx);
						errors++;
					end
					if (exp_q[l].size() != 0) begin
						e  = exp_q[l].pop_front();
						ok = (lane_out[l].v == e.o.v) && (lane_out[l].last == e.o.last)
						     && (lane_out[l].no == e.o.no)
						     && (!e.idx_known || lane_out[l].idx == e.o.idx);
						checks++;
						assert (ok) else begin
							$write("CHECK FAILED at time %0t: lane %0d got ", $time, l);
							$write("v=%0b last=%0b no=%0d idx=%h", lane_out[l].v,
							       lane_out[l].last, lane_out[l].no, lane_out[l].idx);
							$display(", expected v=%0b last=%0b no=%0d idx=%h",
							         e.o.v, e.o.last, e.o.no, e.o.idx);
							errors++;
						end
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		stim_t s;
		clock       = 1'b0;
		reset       = 1'b1;
		stall       = 1'b0;
		req         = 1'b0;
		masked_read = 1'b0;
		cfg         = '0;
		window      = '0;
		length      = '0;
		thread_id   = '0;
		constant    = '0;
		sign        = 1'b0;
		mask        = '0;
		repeat (RESET_CYC) @(posedge clock);
		reset <= 1'b0;

		begin_test("reset state");
		repeat (4) begin
			@(negedge clock);
			for (int l = 0; l < N_LANES; l++) begin
				assert (!busy && !lane_out[l].v && !lane_out[l].last) else begin
					$display("CHECK FAILED at time %0t: lane %0d not idle after reset", $time, l);
					errors++;
				end
			end
		end
		end_test();

		begin_test("pass-through");
		for (int i = 0; i < N_PASS; i++) begin
			s           = random_stim();
			s.cfg.slice = 1'b0;
			s.cfg.v     = 1'(rand_next());
			run_case(s, 1'b0, 1'b0);
		end
		end_test();

		begin_test("plain slice");
		for (int i = 0; i < N_PLAIN; i++) begin
			s                 = random_stim();
			s.cfg.sel.f.sel_s = 1'b0;
			run_case(s, 1'b0, 1'b0);
		end
		end_test();

		begin_test("subtract/swap");
		for (int i = 0; i < N_SIGN; i++) begin
			s                 = random_stim();
			s.sign            = 1'b1;
			s.cfg.sel.f.sel_s = 1'(i);
			run_case(s, 1'b0, 1'b0);
		end
		end_test();

		begin_test("masked slice");
		for (int i = 0; i < N_MASK; i++) begin
			s        = random_stim();
			s.masked = 1'b1;
			s.sign   = 1'(rand_next());
			if (i == N_MASK - 1) s.mask = '0;
			run_case(s, 1'b0, 1'b0);
		end
		end_test();

		begin_test("stall/busy");
		for (int i = 0; i < N_STALL; i++) begin
			s        = random_stim();
			s.masked = 1'(i);
			s.sign   = 1'(rand_next());
			s.length = index_t'(4 + rand_next() % (MAX_LEN - 3));	// Room for the busy poke
			s.mask   = s.mask | MASK_WIDTH'(16'h0003);
			run_case(s, 1'b1, 1'b1);
		end
		end_test();

		$display("Tests run %0d, failed %0d, outputs checked %0d, errors %0d",
		         tests_run, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog sized from the test lengths
	initial begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYC);
		$display("Test failed");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+.
index_pkg.sv
skip_ctrl.sv
index_unit.sv
index_top.sv
tb_index_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module tb_index_top -Mdir "$BUILD_DIR" -o tb_index_top
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/tb_index_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
